// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ipg_top
RTL_TOP   ?= ipg_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter-out tb_%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the trace is opened relative to the project root
run: $(SIM_BIN) ipg_trace.txt
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
ipg_msg_pkg.sv
ipg_blk_pkg.sv
job_fifo_buf.sv
ipg_line_mem.sv
ipg_proc.sv
ipg_top.sv
tb_ipg_top.sv

// File: ipg_blk_pkg.sv
`default_nettype none

package ipg_blk_pkg;

    localparam int chunk_width = 64;
    localparam int len_width   = 6;

    // receive side job queue
    localparam int jobq_depth     = 16;
    localparam int jobq_ptr_width = 4;

    // valid bits are packed from data[63] down; len of 0 means 64
    typedef struct packed {
        logic [chunk_width-1:0] data;
        logic [len_width-1:0]   len;
    } rx_chunk_t;

    localparam int slice_width  = 56;
    localparam int reply_chunks = 10;

    localparam logic [7:0] blk_type_ctrl = 8'h1e;  // all-control block

    typedef struct packed {
        logic [slice_width-1:0] payload;
        logic [7:0]             block_type;
    } reply_chunk_t;

endpackage

`default_nettype wire

// File: ipg_line_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ipg_line_mem (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire logic                                   mem_wr,
    input  wire logic                                   mem_rd,
    input  wire logic [ipg_msg_pkg::mem_index_width-1:0] mem_index,
    input  wire logic [ipg_msg_pkg::line_width-1:0]      mem_wdata,
    output logic [ipg_msg_pkg::line_width-1:0]           mem_rdata
);
    import ipg_msg_pkg::*;

    logic [line_width-1:0] lines [mem_lines];

    // a never-written line reads back as zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < mem_lines; i++) begin
                lines[i] <= '0;
            end
            mem_rdata <= '0;
        end else begin
            if (mem_wr) begin
                lines[mem_index] <= mem_wdata;
            end
            if (mem_rd) begin
                mem_rdata <= lines[mem_index];  // valid the cycle after mem_rd
            end
        end
    end

endmodule

`default_nettype wire

// File: ipg_msg_pkg.sv
`default_nettype none

package ipg_msg_pkg;

    // message field widths, in bits
    localparam int hdr_width   = 16;
    localparam int addr_width  = 128;
    localparam int line_width  = 512;
    localparam int reply_width = hdr_width + line_width;  // 528

    // header and address are gathered as one unit
    localparam int hdr_addr_width = hdr_width + addr_width;

    // wide enough to count down a full payload line
    localparam int bit_cnt_width = 10;

    // line memory geometry
    localparam int mem_lines       = 8;
    localparam int mem_index_width = 3;

    // opcode sits in the top two header bits
    typedef enum logic [1:0] {
        op_nop = 2'b00,  // discarded
        op_rd  = 2'b01,  // read request
        op_wr  = 2'b10,  // write request
        op_rsp = 2'b11   // read reply, never accepted on receive
    } ipg_op_e;

    typedef enum logic [1:0] {
        st_hdr_addr = 2'd0,
        st_payload  = 2'd1,
        st_fetch    = 2'd2,
        st_reply    = 2'd3
    } proc_state_e;

endpackage

`default_nettype wire

// File: ipg_proc.sv
`timescale 1ns/1ps
`default_nettype none

module ipg_proc (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire ipg_blk_pkg::rx_chunk_t                  head,
    input  wire logic                                    empty,
    output logic                                         rd,
    output logic                                         mem_wr,
    output logic                                         mem_rd,
    output logic [ipg_msg_pkg::mem_index_width-1:0]      mem_index,
    output logic [ipg_msg_pkg::line_width-1:0]           mem_wdata,
    input  wire logic [ipg_msg_pkg::line_width-1:0]      mem_rdata,
    output ipg_blk_pkg::reply_chunk_t                    reply_chunk,
    output logic                                         memq_write
);
    import ipg_msg_pkg::*;
    import ipg_blk_pkg::*;

    proc_state_e              state;
    logic [bit_cnt_width-1:0] rem;        // bits still owed to the current field
    logic [3:0]               reply_cnt;

    logic [hdr_addr_width-1:0] hdr_addr;
    logic [hdr_addr_width-1:0] hdr_addr_next;
    logic [line_width-1:0]     payload;
    logic [line_width-1:0]     payload_next;
    logic [reply_width-1:0]    reply_sr;
    logic [reply_width-1:0]    reply_cur;
    logic [hdr_width-1:0]      rsp_hdr;

    logic [6:0]             len_eff;
    logic [6:0]             take;
    logic                   last;
    logic [chunk_width-1:0] top_bits;

    ipg_op_e                 op_in;
    logic [addr_width/2-1:0] src;
    logic [addr_width/2-1:0] dst;
    logic                    msg_ok;

    // bits taken from the head chunk this cycle
    assign len_eff  = (head.len == '0) ? 7'd64 : {1'b0, head.len};
    assign take     = ({3'b0, len_eff} > rem) ? rem[6:0] : len_eff;
    assign last     = ({3'b0, take} == rem);
    assign top_bits = head.data >> (7'd64 - take);  // right-align the msb-first bits

    assign hdr_addr_next = (hdr_addr << take)
                         | {{(hdr_addr_width - chunk_width){1'b0}}, top_bits};
    assign payload_next  = (payload << take)
                         | {{(line_width - chunk_width){1'b0}}, top_bits};

    // decoded from the gathered value, used on the last address pop
    assign op_in  = ipg_op_e'(hdr_addr_next[hdr_addr_width-1 -: 2]);
    assign src    = hdr_addr_next[addr_width-1 -: addr_width/2];
    assign dst    = hdr_addr_next[addr_width/2-1:0];
    assign msg_ok = (src != dst) && (op_in == op_rd || op_in == op_wr);

    assign rd = !empty && (state == st_hdr_addr || state == st_payload);

    assign mem_index = hdr_addr[mem_index_width-1:0];  // low bits of destination
    assign mem_wdata = payload;
    assign mem_rd    = (state == st_fetch);

    assign rsp_hdr   = {op_rsp, {(hdr_width - 2 - mem_index_width){1'b0}}, mem_index};
    // first slice comes straight from the freshly read line
    assign reply_cur = (reply_cnt == '0) ? {rsp_hdr, mem_rdata} : reply_sr;

    assign memq_write  = (state == st_reply);
    assign reply_chunk = '{payload: reply_cur[reply_width-1 -: slice_width],
                           block_type: blk_type_ctrl};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= st_hdr_addr;
            rem       <= bit_cnt_width'(hdr_addr_width);
            reply_cnt <= '0;
            mem_wr    <= 1'b0;
        end else begin
            mem_wr <= 1'b0;
            case (state)
                st_hdr_addr: begin
                    if (!empty) begin
                        rem <= rem - {3'b0, take};
                        if (last) begin
                            rem <= bit_cnt_width'(hdr_addr_width);  // next message
                            if (msg_ok && op_in == op_wr) begin
                                state <= st_payload;
                                rem   <= bit_cnt_width'(line_width);
                            end else if (msg_ok) begin
                                state <= st_fetch;
                            end
                        end
                    end
                end
                st_payload: begin
                    if (!empty) begin
                        rem <= rem - {3'b0, take};
                        if (last) begin
                            mem_wr <= 1'b1;  // line lands one cycle after the last pop
                            rem    <= bit_cnt_width'(hdr_addr_width);
                            state  <= st_hdr_addr;
                        end
                    end
                end
                st_fetch: begin
                    reply_cnt <= '0;
                    state     <= st_reply;
                end
                st_reply: begin
                    reply_cnt <= reply_cnt + 1'b1;
                    if (reply_cnt == 4'(reply_chunks - 1)) begin
                        reply_cnt <= '0;
                        state     <= st_hdr_addr;
                    end
                end
                default: state <= st_hdr_addr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_hdr_addr && !empty) begin
            hdr_addr <= hdr_addr_next;
        end
        if (state == st_payload && !empty) begin
            payload <= payload_next;
        end
        if (state == st_reply) begin
            // ones fill the unused tail of the last chunk
            reply_sr <= {reply_cur[reply_width-slice_width-1:0], {slice_width{1'b1}}};
        end
    end

endmodule

`default_nettype wire

// File: ipg_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipg_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire ipg_blk_pkg::rx_chunk_t rx_chunk,
    input  wire logic                   jobq_write,
    output logic                        jobq_full,
    output ipg_blk_pkg::reply_chunk_t   reply_chunk,
    output logic                        memq_write
);
    import ipg_msg_pkg::*;
    import ipg_blk_pkg::*;

    rx_chunk_t                  head;
    logic                       jobq_empty;
    logic                       jobq_rd;
    logic                       mem_wr;
    logic                       mem_rd;
    logic [mem_index_width-1:0] mem_index;
    logic [line_width-1:0]      mem_wdata;
    logic [line_width-1:0]      mem_rdata;

    job_fifo_buf i_jobq (
        .clk     (clk),
        .reset   (reset),
        .wr      (jobq_write),
        .w_chunk (rx_chunk),
        .rd      (jobq_rd),
        .r_chunk (head),
        .empty   (jobq_empty),
        .full    (jobq_full)
    );

    ipg_proc i_proc (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .empty       (jobq_empty),
        .rd          (jobq_rd),
        .mem_wr      (mem_wr),
        .mem_rd      (mem_rd),
        .mem_index   (mem_index),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .reply_chunk (reply_chunk),
        .memq_write  (memq_write)
    );

    ipg_line_mem i_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_wr    (mem_wr),
        .mem_rd    (mem_rd),
        .mem_index (mem_index),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: ipg_trace.txt
# T test name | C len data, len in hex with 00 for 64 bits, data msb aligned
# E 264 bits of an expected reply in hex, two lines per reply | Q wait until idle
T write_idx5
C 00 8000111122223333
C 00 444400000000abcd
C 10 0005000000000000
C 00 0123456789abcdef
C 00 fedcba9876543210
C 00 0011223344556677
C 00 8899aabbccddeeff
C 00 0f1e2d3c4b5a6978
C 00 8796a5b4c3d2e1f0
C 00 a5a5a5a55a5a5a5a
C 00 deadbeefcafef00d
T write_idx4_mixed_len
C 28 8000222233000000
C 28 3344445555000000
C 00 0000000000001234
C 00 0123456789abcdef
C 00 fedcba9876543210
C 00 0011223344556677
C 00 8899aabbccddeeff
C 00 0f1e2d3c4b5a6978
C 00 8796a5b4c3d2e1f0
C 00 a5a5a5a55a5a5a5a
C 00 deadbeefcafef00d
T drop_messages
C 00 8000000000000000
C 00 000b000000000000
C 10 000b000000000000
C 00 0000000000000000
C 00 0001000000000000
C 10 0002000000000000
C 00 c000000000000000
C 00 0001000000000000
C 10 0002000000000000
Q
T reads_back_to_back
C 00 4000000000000000
C 00 0009000000000000
C 10 0005000000000000
C 10 4000000000000000
C 00 000000000000000a
C 00 000000000000000c
C 00 4000000000000000
C 00 0001000000000000
C 10 000b000000000000
E c0050123456789abcdeffedcba987654321000112233445566778899aabbccddee
E ff0f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a55a5a5a5adeadbeefcafef00d
E c0040123456789abcdeffedcba987654321000112233445566778899aabbccddee
E ff0f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a55a5a5a5adeadbeefcafef00d
E c00300000000000000000000000000000000000000000000000000000000000000
E 000000000000000000000000000000000000000000000000000000000000000000
Q

// File: job_fifo_buf.sv
`timescale 1ns/1ps
`default_nettype none

module job_fifo_buf (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wr,
    input  wire ipg_blk_pkg::rx_chunk_t w_chunk,
    input  wire logic                   rd,
    output ipg_blk_pkg::rx_chunk_t      r_chunk,
    output logic                        empty,
    output logic                        full
);
    import ipg_blk_pkg::*;

    rx_chunk_t                 buf_mem [jobq_depth];
    logic [jobq_ptr_width-1:0] wptr;
    logic [jobq_ptr_width-1:0] rptr;
    logic [jobq_ptr_width:0]   count;  // one extra bit to hold a full count
    logic                      do_wr;
    logic                      do_rd;

    assign do_wr = wr && !full;   // write to a full queue is lost
    assign do_rd = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == (jobq_ptr_width + 1)'(jobq_depth));

    // head shown first-word-fall-through
    assign r_chunk = buf_mem[rptr];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;  // wraps at depth
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            buf_mem[wptr] <= w_chunk;
        end
    end

endmodule

`default_nettype wire

// File: tb_ipg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipg_top;
    import ipg_msg_pkg::*;
    import ipg_blk_pkg::*;

    logic         clk;
    logic         reset;
    rx_chunk_t    rx_chunk;
    logic         jobq_write;
    logic         jobq_full;
    reply_chunk_t reply_chunk;
    logic         memq_write;

    string        trace_lines[$];
    string        test_name = "none";
    reply_chunk_t exp_q[$];        // expected reply chunks in arrival order
    reply_chunk_t got_q[$];        // chunks seen on memq_write
    logic [527:0] exp_reply;
    int           exp_halves = 0;
    int           watchdog_cycles = 0;
    int           sent_since_idle = 0;  // chunks taken since the queue was last empty
    int           run_len = 0;          // consecutive cycles of the current reply

    ipg_top i_ipg_top (
        .clk         (clk),
        .reset       (reset),
        .rx_chunk    (rx_chunk),
        .jobq_write  (jobq_write),
        .jobq_full   (jobq_full),
        .reply_chunk (reply_chunk),
        .memq_write  (memq_write)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // each reply cycle holds exactly one falling edge
    // a reply is ten chunks on consecutive cycles
    always @(negedge clk) begin
        if (reset && memq_write) begin
            got_q.push_back(reply_chunk);
            run_len++;
        end else if (run_len != 0 && run_len != reply_chunks) begin
            abort_run($sformatf("%s: a reply ran for %0d consecutive cycles instead of %0d",
                                test_name, run_len, reply_chunks));
        end else begin
            run_len = 0;
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout: run did not end within %0d cycles", watchdog_cycles));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_chunk(input int idx, input reply_chunk_t exp_c,
                               input reply_chunk_t act_c);
        if (act_c !== exp_c) begin
            abort_run($sformatf("Fail %s chunk %0d: expected %h actual %h",
                                test_name, idx, exp_c, act_c));
        end
    endtask

    task automatic check_full(input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("Fail %s jobq_full: expected %b actual %b",
                                test_name, exp_v, act_v));
        end
    endtask

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("ipg_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open ipg_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blanks
                    trace_lines.push_back(line);
                end
            end
            $fclose(fd);
            if (trace_lines.size() == 0) begin
                abort_run("ipg_trace.txt holds no trace lines");
            end
        end
    endtask

    // entered on a falling edge and returns on the next one after the chunk is taken
    task automatic send_chunk(input rx_chunk_t c);
        // fewer chunks than the queue depth since it was last empty cannot fill it
        if (sent_since_idle < jobq_depth) begin
            check_full(1'b0, jobq_full);
        end
        while (jobq_full) begin
            jobq_write = 1'b0;
            @(negedge clk);
        end
        rx_chunk   = c;
        jobq_write = 1'b1;
        sent_since_idle++;
        @(negedge clk);
    endtask

    // 528-bit reply in ten 56-bit slices with a ones-filled tail
    task automatic add_expected_half(input logic [263:0] half);
        logic [559:0] padded;
        reply_chunk_t ch;
        exp_reply = {exp_reply[263:0], half};
        exp_halves++;
        if (exp_halves == 2) begin
            padded = {exp_reply, 32'hffff_ffff};
            for (int k = 0; k < 10; k++) begin
                ch.payload    = padded[559 - 56*k -: 56];
                ch.block_type = 8'h1e;
                exp_q.push_back(ch);
            end
            exp_halves = 0;
        end
    endtask

    task automatic wait_idle();
        jobq_write = 1'b0;
        while (!(i_ipg_top.jobq_empty && i_ipg_top.i_proc.state == st_hdr_addr)) begin
            @(negedge clk);
        end
        check_full(1'b0, jobq_full);  // queue is empty here
        sent_since_idle = 0;
    endtask

    task automatic drain_and_check();
        reply_chunk_t exp_c;
        reply_chunk_t act_c;
        int           idx;
        idx = 0;
        while (exp_q.size() != 0 && got_q.size() != 0) begin
            exp_c = exp_q.pop_front();
            act_c = got_q.pop_front();
            check_chunk(idx, exp_c, act_c);
            idx++;
        end
        if (got_q.size() != 0) begin
            abort_run($sformatf("%s: %0d reply chunks arrived that the trace does not expect",
                                test_name, got_q.size()));
        end else if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: %0d expected reply chunks never arrived",
                                test_name, exp_q.size()));
        end
    endtask

    task automatic run_line(input string line);
        logic [5:0]   len_v;
        logic [63:0]  data_v;
        logic [263:0] half;
        case (line.getc(0))
            "T": void'($sscanf(line, "T %s", test_name));
            "C": begin
                if ($sscanf(line, "C %h %h", len_v, data_v) != 2) begin
                    abort_run({"malformed chunk line: ", line});
                end else begin
                    send_chunk('{data: data_v, len: len_v});
                end
            end
            "E": begin
                if ($sscanf(line, "E %h", half) != 1) begin
                    abort_run({"malformed expect line: ", line});
                end else begin
                    add_expected_half(half);
                end
            end
            "Q": begin
                wait_idle();
                drain_and_check();
            end
            default: abort_run({"unknown trace line: ", line});
        endcase
    endtask

    initial begin
        rx_chunk   = '0;
        jobq_write = 1'b0;
        reset      = 1'b0;
        load_trace();
        watchdog_cycles = 200 * trace_lines.size();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        foreach (trace_lines[i]) begin
            run_line(trace_lines[i]);
        end
        wait_idle();
        drain_and_check();
        if (exp_halves != 0) begin
            abort_run("trace ends inside an expected reply");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
